/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // word address width, one address per 32-bit word
    localparam int ADDR_SIZE = 8;

    // data word width
    localparam int WORD_SIZE = 32;

    // number of store buffer entries
    // default depth of the store buffer instance
    localparam int SB_DEPTH = 4;

    // data memory size in words
    // one word for every address
    localparam int MEM_WORDS = 2 ** ADDR_SIZE;

    // memory operation presented on the lsu port
    // none marks an idle cycle, which is the only drain chance
    typedef enum logic [1:0] {
        MEMOP_NONE  = 2'b00,
        MEMOP_LOAD  = 2'b01,
        MEMOP_STORE = 2'b10
    } memop_e;

endpackage : lsu_pkg

`default_nettype wire

/* hw/sb_drain_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface sb_drain_if;

    import lsu_pkg::*;

    // level from the memory side, high in idle cycles
    logic                 chance;

    // buffer side has an entry to write back
    logic                 valid;

    // oldest entry, valid together with valid
    logic [ADDR_SIZE-1:0] addr;
    logic [WORD_SIZE-1:0] data;

    // write happens at the edge where chance and valid are both high
    // there is no acknowledge, the buffer retires the entry on the same edge
    modport buffer (
        input  chance,
        output valid,
        output addr,
        output data
    );

    modport memory (
        output chance,
        input  valid,
        input  addr,
        input  data
    );

endinterface : sb_drain_if

`default_nettype wire

/* hw/store_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module store_buffer #(
    parameter int DEPTH = lsu_pkg::SB_DEPTH
) (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire lsu_pkg::memop_e                op_i,
    input  wire logic [lsu_pkg::ADDR_SIZE-1:0]  addr_i,
    input  wire logic [lsu_pkg::WORD_SIZE-1:0]  wdata_i,
    output logic                                stall_o,
    output logic                                fwd_hit_o,
    output logic [lsu_pkg::WORD_SIZE-1:0]       fwd_data_o,
    sb_drain_if.buffer                          drain
);

    import lsu_pkg::*;

    // entry storage
    logic [DEPTH-1:0]     entry_valid;
    logic [ADDR_SIZE-1:0] entry_addr [DEPTH];
    logic [WORD_SIZE-1:0] entry_data [DEPTH];

    // head is the next free slot, tail the oldest entry
    logic [$clog2(DEPTH)-1:0] head;
    logic [$clog2(DEPTH)-1:0] tail;

    // occupancy, one extra bit so that full and empty differ
    logic [$clog2(DEPTH):0] count;

    logic [DEPTH-1:0] hit_vec;
    logic             hit;
    logic             full;
    logic             empty;
    logic             is_store;
    logic             push;
    logic             pop;

    // address match against every live entry
    // coalescing keeps this one-hot or zero
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            hit_vec[i] = entry_valid[i] && (entry_addr[i] == addr_i);
        end
    end

    assign hit   = |hit_vec;
    assign full  = (count == ($clog2(DEPTH)+1)'(DEPTH));
    assign empty = (count == '0);

    assign is_store = (op_i == MEMOP_STORE);

    // a new address with no room left holds the requester
    assign stall_o = is_store && full && !hit;

    // a store miss takes the head slot
    assign push = is_store && !hit && !full;

    // drain fires only on the edge both sides agree on
    assign pop = drain.chance && drain.valid;

    // forward path, one-hot mux built as an or of masked words
    always_comb begin
        fwd_data_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (hit_vec[i]) begin
                fwd_data_o = fwd_data_o | entry_data[i];
            end
        end
    end

    assign fwd_hit_o = hit;

    // oldest entry goes out in idle cycles
    assign drain.valid = drain.chance && !empty;
    assign drain.addr  = entry_addr[tail];
    assign drain.data  = entry_data[tail];

    // valid bits, pointers and occupancy
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            entry_valid <= '0;
            head        <= '0;
            tail        <= '0;
            count       <= '0;
        end else begin
            if (push) begin
                entry_valid[head] <= 1'b1;
                // explicit wrap keeps non power of two depths correct
                if (head == ($clog2(DEPTH))'(DEPTH-1)) begin
                    head <= '0;
                end else begin
                    head <= head + 1'b1;
                end
            end
            if (pop) begin
                entry_valid[tail] <= 1'b0;
                if (tail == ($clog2(DEPTH))'(DEPTH-1)) begin
                    tail <= '0;
                end else begin
                    tail <= tail + 1'b1;
                end
            end
            // push and pop never share a cycle, store vs idle
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk_i) begin
        if (is_store) begin
            if (hit) begin
                // coalesce, the address stays the same
                for (int i = 0; i < DEPTH; i++) begin
                    if (hit_vec[i]) begin
                        entry_data[i] <= wdata_i;
                    end
                end
            end else if (!full) begin
                entry_addr[head] <= addr_i;
                entry_data[head] <= wdata_i;
            end
        end
    end

endmodule : store_buffer

`default_nettype wire

/* hw/data_mem_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module data_mem_ctrl (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire lsu_pkg::memop_e                op_i,
    input  wire logic [lsu_pkg::ADDR_SIZE-1:0]  addr_i,
    input  wire logic                           fwd_hit_i,
    input  wire logic [lsu_pkg::WORD_SIZE-1:0]  fwd_data_i,
    output logic                                load_valid_o,
    output logic                                load_fwd_o,
    output logic [lsu_pkg::WORD_SIZE-1:0]       load_data_o,
    sb_drain_if.memory                          drain
);

    import lsu_pkg::*;

    // word array, contents undefined until written
    logic [WORD_SIZE-1:0] mem [MEM_WORDS];

    // per word written flag, this is what makes memory read zero
    logic [MEM_WORDS-1:0] written;

    logic                 is_load;
    logic                 load_q;
    logic                 fwd_q;
    logic [WORD_SIZE-1:0] fwd_data_q;
    logic [WORD_SIZE-1:0] mem_rdata_q;

    assign is_load = (op_i == MEMOP_LOAD);

    // only idle cycles give the buffer a slot
    assign drain.chance = (op_i == MEMOP_NONE);

    // drain write into the array
    always_ff @(posedge clk_i) begin
        if (drain.chance && drain.valid) begin
            mem[drain.addr] <= drain.data;
        end
    end

    // written bits follow the drain writes
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            written <= '0;
        end else if (drain.chance && drain.valid) begin
            written[drain.addr] <= 1'b1;
        end
    end

    // load control flags
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            load_q <= 1'b0;
            fwd_q  <= 1'b0;
        end else begin
            load_q <= is_load;
            // hit only counts when this cycle is a load
            fwd_q  <= is_load && fwd_hit_i;
        end
    end

    // load data capture, synchronous memory read
    // no drain can land on this edge since the cycle is a load
    always_ff @(posedge clk_i) begin
        if (is_load) begin
            fwd_data_q  <= fwd_data_i;
            mem_rdata_q <= written[addr_i] ? mem[addr_i] : '0;
        end
    end

    assign load_valid_o = load_q;
    assign load_fwd_o   = fwd_q;

    // buffered word wins over the older memory copy
    assign load_data_o  = fwd_q ? fwd_data_q : mem_rdata_q;

endmodule : data_mem_ctrl

`default_nettype wire

/* hw/lsu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_top (
    input  wire logic                           clk_i,
    input  wire logic                           arst_n_i,
    input  wire lsu_pkg::memop_e                op_i,
    input  wire logic [lsu_pkg::ADDR_SIZE-1:0]  addr_i,
    input  wire logic [lsu_pkg::WORD_SIZE-1:0]  wdata_i,
    output logic                                stall_o,
    output logic                                load_valid_o,
    output logic                                load_fwd_o,
    output logic [lsu_pkg::WORD_SIZE-1:0]       load_data_o
);

    import lsu_pkg::*;

    // forwarding result from buffer to controller
    logic                 fwd_hit;
    logic [WORD_SIZE-1:0] fwd_data;

    // write-back path between buffer and memory
    sb_drain_if drain_if ();

    // stores land here first, loads look here before memory
    store_buffer #(
        .DEPTH      (SB_DEPTH)
    ) i_store_buffer (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .op_i       (op_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .stall_o    (stall_o),
        .fwd_hit_o  (fwd_hit),
        .fwd_data_o (fwd_data),
        .drain      (drain_if.buffer)
    );

    // memory array, drain timing and load result register
    data_mem_ctrl i_data_mem_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .fwd_hit_i    (fwd_hit),
        .fwd_data_i   (fwd_data),
        .load_valid_o (load_valid_o),
        .load_fwd_o   (load_fwd_o),
        .load_data_o  (load_data_o),
        .drain        (drain_if.memory)
    );

endmodule : lsu_top

`default_nettype wire

/* tests/lsu_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module lsu_assertions (
    input  wire logic            clk_i,
    input  wire logic            arst_n_i,
    input  wire lsu_pkg::memop_e op_i,
    input  wire logic            stall_o,
    input  wire logic            load_valid_o,
    input  wire logic            load_fwd_o,
    input  wire logic            drain_valid
);

    import lsu_pkg::*;

    // stall only ever holds back a store
    a_stall_store : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stall_o |-> (op_i == MEMOP_STORE))
        else $error("stall_o high while op_i is not a store");

    // fixed one cycle load latency in both directions
    a_load_next : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (op_i == MEMOP_LOAD) |=> load_valid_o)
        else $error("load_valid_o missing one cycle after a load");

    a_load_prev : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        load_valid_o |-> ($past(op_i) == MEMOP_LOAD))
        else $error("load_valid_o without a load in the previous cycle");

    // forward flag only qualifies a valid result
    a_fwd_valid : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        load_fwd_o |-> load_valid_o)
        else $error("load_fwd_o high without load_valid_o");

    // buffer may only offer a write in an idle cycle of the port
    a_drain_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        drain_valid |-> (op_i == MEMOP_NONE))
        else $error("drain valid high while the port carries an operation");

endmodule : lsu_assertions

bind lsu_top lsu_assertions i_lsu_assertions (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .op_i         (op_i),
    .stall_o      (stall_o),
    .load_valid_o (load_valid_o),
    .load_fwd_o   (load_fwd_o),
    .drain_valid  (drain_if.valid)
);

`default_nettype wire

/* tests/tb_lsu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_lsu;

    import lsu_pkg::*;

    localparam int RESET_CYCLES   = 10;
    localparam int RANDOM_OPS     = 400;
    // a stalled store costs up to three cycles and the directed tests need under 200
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * RANDOM_OPS + 200;

    logic                 clk_i;
    logic                 arst_n_i;
    memop_e               op_i;
    logic [ADDR_SIZE-1:0] addr_i;
    logic [WORD_SIZE-1:0] wdata_i;
    logic                 stall_o;
    logic                 load_valid_o;
    logic                 load_fwd_o;
    logic [WORD_SIZE-1:0] load_data_o;

    // reference memory defaults to zero and a queue mirrors the buffer
    logic [WORD_SIZE-1:0] mem_model [logic [ADDR_SIZE-1:0]];
    logic [ADDR_SIZE-1:0] q_addr [$];
    logic [WORD_SIZE-1:0] q_data [$];

    // load presented last cycle whose result is due now
    logic                 pend_load;
    logic                 pend_fwd;
    logic [WORD_SIZE-1:0] pend_data;

    logic [31:0] rand_state = 32'd65;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_fails = 0;
    int          cycles     = 0;

    lsu_top i_dut (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .stall_o      (stall_o),
        .load_valid_o (load_valid_o),
        .load_fwd_o   (load_fwd_o),
        .load_data_o  (load_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // run limit
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic logic [WORD_SIZE-1:0] mem_read(input logic [ADDR_SIZE-1:0] addr);
        if (mem_model.exists(addr)) begin
            return mem_model[addr];
        end
        return '0;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) begin
            pass_count++;
        end else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            fail_count++;
            test_fails++;
        end
    endtask

    // result of the load from the previous cycle or quiet outputs
    task automatic verify_load_result();
        if (pend_load) begin
            compare_value("load_valid_o", 1, load_valid_o);
            compare_value("load_fwd_o", pend_fwd, load_fwd_o);
            compare_value("load_data_o", pend_data, load_data_o);
            pend_load = 1'b0;
        end else begin
            compare_value("load_valid_o", 0, load_valid_o);
            compare_value("load_fwd_o", 0, load_fwd_o);
        end
    endtask

    // one operation driven at the rising edge and checked at the falling edge
    task automatic run_cycle(input memop_e op, input logic [ADDR_SIZE-1:0] addr,
                             input logic [WORD_SIZE-1:0] data, output logic stalled);
        logic hit;
        int   idx;
        logic exp_stall;
        @(posedge clk_i);
        op_i    <= op;
        addr_i  <= addr;
        wdata_i <= data;
        @(negedge clk_i);
        verify_load_result();
        hit = 1'b0;
        idx = 0;
        foreach (q_addr[i]) begin
            if (q_addr[i] == addr) begin
                hit = 1'b1;
                idx = i;
            end
        end
        exp_stall = (op == MEMOP_STORE) && !hit && (q_addr.size() == SB_DEPTH);
        compare_value("stall_o", exp_stall, stall_o);
        stalled = stall_o;
        if (op == MEMOP_LOAD) begin
            pend_load = 1'b1;
            pend_fwd  = hit;
            pend_data = hit ? q_data[idx] : mem_read(addr);
        end else if (op == MEMOP_STORE) begin
            if (!exp_stall && hit) begin
                q_data[idx] = data;
            end else if (!exp_stall) begin
                q_addr.push_back(addr);
                q_data.push_back(data);
            end
        end else if (q_addr.size() > 0) begin
            // idle cycle writes the oldest entry back
            mem_model[q_addr[0]] = q_data[0];
            void'(q_addr.pop_front());
            void'(q_data.pop_front());
        end
    endtask

    task automatic idle_cycle();
        logic unused;
        run_cycle(MEMOP_NONE, '0, '0, unused);
    endtask

    task automatic load_word(input logic [ADDR_SIZE-1:0] addr);
        logic unused;
        run_cycle(MEMOP_LOAD, addr, '0, unused);
    endtask

    // requester side of a stall inserts an idle cycle and presents again
    task automatic store_word(input logic [ADDR_SIZE-1:0] addr,
                              input logic [WORD_SIZE-1:0] data);
        logic stalled;
        run_cycle(MEMOP_STORE, addr, data, stalled);
        while (stalled) begin
            idle_cycle();
            run_cycle(MEMOP_STORE, addr, data, stalled);
        end
    endtask

    task automatic drain_model();
        while (q_addr.size() > 0) begin
            idle_cycle();
        end
        idle_cycle();
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, test_fails);
        test_fails = 0;
    endtask

    initial begin
        logic [31:0]          r;
        logic [31:0]          r_addr;
        logic                 stalled;
        logic [ADDR_SIZE-1:0] held;
        logic [WORD_SIZE-1:0] held_data;
        op_i      = MEMOP_NONE;
        addr_i    = '0;
        wdata_i   = '0;
        arst_n_i  = 1'b0;
        pend_load = 1'b0;
        pend_fwd  = 1'b0;
        pend_data = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        arst_n_i <= 1'b1;

        // quiet outputs and zero memory after reset
        repeat (4) idle_cycle();
        for (int a = 8'h10; a < 8'h14; a++) begin
            load_word(a);
        end
        idle_cycle();
        report_test("reset");

        // mixed traffic over eight addresses with two stores per load
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r      = next_rand();
            r_addr = next_rand();
            case (r[31:30])
                2'd0: idle_cycle();
                2'd1: load_word({5'd0, r_addr[26:24]});
                default: store_word({5'd0, r_addr[26:24]}, next_rand());
            endcase
        end
        idle_cycle();
        report_test("random");

        // fill the buffer with new addresses so that the fifth one stalls
        drain_model();
        for (int i = 0; i < SB_DEPTH; i++) begin
            run_cycle(MEMOP_STORE, 8'h40 + i, next_rand(), stalled);
        end
        held_data = next_rand();
        run_cycle(MEMOP_STORE, 8'h40 + SB_DEPTH, held_data, stalled);
        compare_value("stall_o", 1, stalled);
        idle_cycle();
        // the same store is taken after one idle cycle
        run_cycle(MEMOP_STORE, 8'h40 + SB_DEPTH, held_data, stalled);
        compare_value("stall_o", 0, stalled);
        report_test("stall");

        // stores to a held address coalesce in a full buffer
        held = q_addr[1];
        for (int i = 0; i < 8; i++) begin
            run_cycle(MEMOP_STORE, held, next_rand(), stalled);
            compare_value("stall_o", 0, stalled);
        end
        foreach (q_addr[i]) begin
            load_word(q_addr[i]);
        end
        idle_cycle();
        report_test("coalesce");

        // with everything written back the loads come from memory
        drain_model();
        foreach (mem_model[a]) begin
            load_word(a);
        end
        idle_cycle();
        report_test("drain");

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_lsu

`default_nettype wire

/* files.f */
hw/lsu_pkg.sv
hw/sb_drain_if.sv
hw/store_buffer.sv
hw/data_mem_ctrl.sv
hw/lsu_top.sv
tests/lsu_assertions.sv
tests/tb_lsu.sv

/* Bender.yml */
package:
  name: lsu

sources:
  # design, in compile order
  - hw/lsu_pkg.sv
  - hw/sb_drain_if.sv
  - hw/store_buffer.sv
  - hw/data_mem_ctrl.sv
  - hw/lsu_top.sv

  # verification
  - target: test
    files:
      - tests/lsu_assertions.sv
      - tests/tb_lsu.sv
